//--- src/camEdgePkg.sv
package camEdgePkg;

  // ========================================
  // Pixel and coordinate types
  // ========================================
  typedef logic [11:0] pixelT;
  typedef logic [15:0] coordT;
  typedef logic [31:0] frameCountT;

  // One raw line fits in a line buffer
  localparam int lineDepth = 1024;
  typedef logic [9:0] lineAddrT;

  // ========================================
  // APB register map
  // ========================================
  typedef logic [3:0]  apbAddrT;
  typedef logic [31:0] apbDataT;

  localparam apbAddrT regCtrl   = 4'h0;
  localparam apbAddrT regView   = 4'h4;
  localparam apbAddrT regFrames = 4'h8;
  localparam apbAddrT regStatus = 4'hC;

  // Output stream selection
  typedef enum logic [2:0] {
    viewRaw   = 3'd0,
    viewGray  = 3'd1,
    viewHoriz = 3'd2,
    viewVert  = 3'd3,
    viewEdges = 3'd4
  } viewModeT;

endpackage

//--- src/lineBuffer.sv
`timescale 1ns/1ps

module lineBuffer
  import camEdgePkg::*;
(
  input  logic     D5M_PIXLCLK,
  input  logic     wrEn,
  input  lineAddrT addr,
  input  pixelT    wrData,
  output pixelT    rdData
);

  pixelT mem [lineDepth];

  // Old value at addr, before this cycle's write
  assign rdData = mem[addr];

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (wrEn)
    begin
      mem[addr] <= wrData;
    end
  end

endmodule

//--- src/ctrlRegs.sv
`timescale 1ns/1ps

module ctrlRegs
  import camEdgePkg::*;
(
  input  logic       D5M_PIXLCLK,
  input  logic       rst,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apbAddrT    paddr,
  input  apbDataT    pwdata,
  output apbDataT    prdata,
  output logic       pready,
  output logic       pslverr,
  input  frameCountT frameCount,
  input  logic       armed,
  input  logic       capturing,
  output logic       armReq,
  output logic       disarmReq,
  output viewModeT   viewMode
);

  logic access;
  logic addrHit;
  logic writeEn;

  // Access phase of a zero-wait transfer
  assign access = psel && penable;

  assign addrHit = (paddr == regCtrl) || (paddr == regView) ||
                   (paddr == regFrames) || (paddr == regStatus);

  assign pready  = 1'b1;
  assign pslverr = access && !addrHit;
  assign writeEn = access && pwrite && addrHit;

  // ========================================
  // Write side
  // ========================================
  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (rst)
    begin
      armReq    <= 1'b0;
      disarmReq <= 1'b0;
      viewMode  <= viewRaw;
    end
    else
    begin
      // Command bits give single-cycle pulses
      armReq    <= writeEn && (paddr == regCtrl) && pwdata[0];
      disarmReq <= writeEn && (paddr == regCtrl) && pwdata[1];
      if (writeEn && (paddr == regView))
      begin
        viewMode <= viewModeT'(pwdata[2:0]);
      end
    end
  end

  // Read mux
  // CTRL reads as zero
  always_comb
  begin
    prdata = '0;
    case (paddr)
      regView:   prdata = apbDataT'(viewMode);
      regFrames: prdata = frameCount;
      regStatus: prdata = {30'd0, capturing, armed};
      default:   prdata = '0;
    endcase
  end

endmodule

//--- src/frameCapture.sv
`timescale 1ns/1ps

module frameCapture
  import camEdgePkg::*;
(
  input  logic       D5M_PIXLCLK,
  input  logic       rst,
  input  pixelT      D5M_D,
  input  logic       D5M_FVAL,
  input  logic       D5M_LVAL,
  input  logic       armReq,
  input  logic       disarmReq,
  output logic       armed,
  output logic       capturing,
  output pixelT      rawPix,
  output logic       rawValid,
  output coordT      pixX,
  output coordT      pixY,
  output frameCountT frameCount
);

  pixelT dReg;
  logic  fvalReg, lvalReg;
  logic  prevFval, prevLval;
  coordT xNext, yCur;
  coordT colNow, rowNow;
  logic  startNow, fvalFall, lineDone, pixelValid;

  // Edges of the registered sync pins
  assign startNow   = fvalReg && !prevFval && armed;
  assign fvalFall   = prevFval && !fvalReg;
  assign lineDone   = prevLval && !lvalReg && capturing;
  assign pixelValid = fvalReg && lvalReg && (capturing || startNow);

  // First pixel of a frame may coincide with its start
  assign colNow = startNow ? '0 : xNext;
  assign rowNow = startNow ? '0 : yCur;

  // ========================================
  // Control state
  // ========================================
  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (rst)
    begin
      fvalReg    <= 1'b0;
      lvalReg    <= 1'b0;
      prevFval   <= 1'b0;
      prevLval   <= 1'b0;
      armed      <= 1'b0;
      capturing  <= 1'b0;
      rawValid   <= 1'b0;
      xNext      <= '0;
      yCur       <= '0;
      frameCount <= '0;
    end
    else
    begin
      fvalReg  <= D5M_FVAL;
      lvalReg  <= D5M_LVAL;
      prevFval <= fvalReg;
      prevLval <= lvalReg;
      // Disarm has priority
      if (disarmReq)
        armed <= 1'b0;
      else if (armReq)
        armed <= 1'b1;
      if (startNow)
        capturing <= 1'b1;
      else if (fvalFall)
        capturing <= 1'b0;
      if (fvalFall && capturing)
        frameCount <= frameCount + 1'b1;
      rawValid <= pixelValid;
      if (pixelValid)
        xNext <= colNow + 1'b1;
      else if (lineDone || startNow)
        xNext <= '0;
      // Only lines that carried pixels advance the row
      if (startNow)
        yCur <= '0;
      else if (lineDone && (xNext != '0))
        yCur <= yCur + 1'b1;
    end
  end

  // Pixel data path
  always_ff @(posedge D5M_PIXLCLK)
  begin
    dReg   <= D5M_D;
    rawPix <= dReg;
    pixX   <= colNow;
    pixY   <= rowNow;
  end

endmodule

//--- src/bayerGray.sv
`timescale 1ns/1ps

module bayerGray
  import camEdgePkg::*;
(
  input  logic  D5M_PIXLCLK,
  input  logic  rst,
  input  pixelT rawPix,
  input  logic  rawValid,
  input  coordT pixX,
  input  coordT pixY,
  output pixelT gray,
  output logic  grayValid,
  output coordT grayX,
  output coordT grayY
);

  pixelT       abovePix;
  pixelT       leftCur;
  pixelT       leftUp;
  logic [13:0] blockSum;
  logic        blockDone;

  // Previous raw row at the same column
  lineBuffer rowStore (
    .D5M_PIXLCLK (D5M_PIXLCLK),
    .wrEn        (rawValid),
    .addr        (lineAddrT'(pixX)),
    .wrData      (rawPix),
    .rdData      (abovePix)
  );

  // Bottom-right pixel of a 2x2 block
  assign blockDone = rawValid && pixX[0] && pixY[0];

  assign blockSum = 14'(leftCur) + 14'(leftUp) + 14'(rawPix) + 14'(abovePix);

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (rst)
      grayValid <= 1'b0;
    else
      grayValid <= blockDone;
  end

  // Left neighbours of the current and upper rows
  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (rawValid)
    begin
      leftCur <= rawPix;
      leftUp  <= abovePix;
    end
    if (blockDone)
    begin
      gray  <= blockSum[13:2];
      grayX <= pixX >> 1;
      grayY <= pixY >> 1;
    end
  end

endmodule

//--- src/edgeDetect.sv
`timescale 1ns/1ps

module edgeDetect
  import camEdgePkg::*;
(
  input  logic  D5M_PIXLCLK,
  input  logic  rst,
  input  pixelT gray,
  input  logic  grayValid,
  input  coordT grayX,
  input  coordT grayY,
  output pixelT horizEdge,
  output pixelT vertEdge,
  output logic  edgeValid
);

  pixelT upStored;
  pixelT prevGray;
  pixelT leftPix;
  pixelT upPix;

  function automatic pixelT absDiff(input pixelT a, input pixelT b);
    if (a > b)
      return a - b;
    else
      return b - a;
  endfunction

  // Previous gray row
  lineBuffer grayRow (
    .D5M_PIXLCLK (D5M_PIXLCLK),
    .wrEn        (grayValid),
    .addr        (lineAddrT'(grayX)),
    .wrData      (gray),
    .rdData      (upStored)
  );

  // Missing neighbours at the image border give zero
  assign leftPix = (grayX == '0) ? gray : prevGray;
  assign upPix   = (grayY == '0) ? gray : upStored;

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (rst)
      edgeValid <= 1'b0;
    else
      edgeValid <= grayValid;
  end

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (grayValid)
    begin
      prevGray  <= gray;
      horizEdge <= absDiff(gray, leftPix);
      vertEdge  <= absDiff(gray, upPix);
    end
  end

endmodule

//--- src/viewSelect.sv
`timescale 1ns/1ps

module viewSelect
  import camEdgePkg::*;
(
  input  logic     D5M_PIXLCLK,
  input  logic     rst,
  input  viewModeT viewMode,
  input  pixelT    rawPix,
  input  logic     rawValid,
  input  pixelT    gray,
  input  logic     grayValid,
  input  pixelT    horizEdge,
  input  pixelT    vertEdge,
  input  logic     edgeValid,
  output pixelT    pixOut,
  output logic     pixValid
);

  pixelT selPix;
  logic  selValid;

  // Unknown modes fall back to raw
  always_comb
  begin
    case (viewMode)
      viewGray:
      begin
        selPix   = gray;
        selValid = grayValid;
      end
      viewHoriz:
      begin
        selPix   = horizEdge;
        selValid = edgeValid;
      end
      viewVert:
      begin
        selPix   = vertEdge;
        selValid = edgeValid;
      end
      viewEdges:
      begin
        selPix   = horizEdge | vertEdge;
        selValid = edgeValid;
      end
      default:
      begin
        selPix   = rawPix;
        selValid = rawValid;
      end
    endcase
  end

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (rst)
      pixValid <= 1'b0;
    else
      pixValid <= selValid;
  end

  always_ff @(posedge D5M_PIXLCLK)
  begin
    pixOut <= selPix;
  end

endmodule

//--- src/camEdgeTop.sv
`timescale 1ns/1ps

module camEdgeTop
  import camEdgePkg::*;
(
  input  logic    D5M_PIXLCLK,
  input  logic    rst,
  input  pixelT   D5M_D,
  input  logic    D5M_FVAL,
  input  logic    D5M_LVAL,
  input  logic    psel,
  input  logic    penable,
  input  logic    pwrite,
  input  apbAddrT paddr,
  input  apbDataT pwdata,
  output apbDataT prdata,
  output logic    pready,
  output logic    pslverr,
  output pixelT   pixOut,
  output logic    pixValid
);

  // ========================================
  // Internal wires
  // ========================================
  logic       armReq, disarmReq;
  logic       armed, capturing;
  viewModeT   viewMode;
  frameCountT frameCount;
  pixelT      rawPix, gray, horizEdge, vertEdge;
  logic       rawValid, grayValid, edgeValid;
  coordT      pixX, pixY, grayX, grayY;

  // Register block
  ctrlRegs regs (
    .D5M_PIXLCLK (D5M_PIXLCLK), .rst (rst),
    .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
    .pready (pready), .pslverr (pslverr),
    .frameCount (frameCount), .armed (armed), .capturing (capturing),
    .armReq (armReq), .disarmReq (disarmReq), .viewMode (viewMode)
  );

  // Sensor capture
  frameCapture capture (
    .D5M_PIXLCLK (D5M_PIXLCLK), .rst (rst),
    .D5M_D (D5M_D), .D5M_FVAL (D5M_FVAL), .D5M_LVAL (D5M_LVAL),
    .armReq (armReq), .disarmReq (disarmReq),
    .armed (armed), .capturing (capturing),
    .rawPix (rawPix), .rawValid (rawValid),
    .pixX (pixX), .pixY (pixY), .frameCount (frameCount)
  );

  // Processing chain
  bayerGray toGray (
    .D5M_PIXLCLK (D5M_PIXLCLK), .rst (rst),
    .rawPix (rawPix), .rawValid (rawValid), .pixX (pixX), .pixY (pixY),
    .gray (gray), .grayValid (grayValid), .grayX (grayX), .grayY (grayY)
  );

  edgeDetect edges (
    .D5M_PIXLCLK (D5M_PIXLCLK), .rst (rst),
    .gray (gray), .grayValid (grayValid), .grayX (grayX), .grayY (grayY),
    .horizEdge (horizEdge), .vertEdge (vertEdge), .edgeValid (edgeValid)
  );

  viewSelect select (
    .D5M_PIXLCLK (D5M_PIXLCLK), .rst (rst), .viewMode (viewMode),
    .rawPix (rawPix), .rawValid (rawValid),
    .gray (gray), .grayValid (grayValid),
    .horizEdge (horizEdge), .vertEdge (vertEdge), .edgeValid (edgeValid),
    .pixOut (pixOut), .pixValid (pixValid)
  );

endmodule

//--- bench/pixelChecker.sv
`timescale 1ns/1ps

module pixelChecker
  import camEdgePkg::*;
(
  input  logic    D5M_PIXLCLK,
  input  logic    rst,
  input  logic    psel,
  input  logic    penable,
  input  logic    pready,
  input  logic    pslverr,
  input  apbDataT prdata,
  input  pixelT   pixOut,
  input  logic    pixValid,
  input  logic    endOfTest,
  output int      pixSeen,
  output int      pixErrors,
  output int      regErrors
);

  pixelT   pixQ [$];
  apbDataT dataQ [$];
  logic    errQ [$];
  logic    writeQ [$];
  pixelT   expPix;
  apbDataT expData;
  logic    expErr;
  logic    expWrite;
  logic    pixDone;
  logic    regDone;
  int      pixFails;
  int      regFails;

  // Expected transfers and pixels in file order
  initial
  begin : loadExpected
    int          fd;
    int          code;
    int          n;
    byte         cmd;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    pixelT       v;
    string       lineText;
    pixSeen   = 0;
    pixErrors = 0;
    regErrors = 0;
    pixDone   = 1'b0;
    regDone   = 1'b0;
    fd = $fopen("bench/camEdge_stimulus.txt", "r");
    if (fd != 0)
    begin
      while ($fscanf(fd, " %c", cmd) == 1)
      begin
        if (cmd == "W" || cmd == "R")
        begin
          code = $fscanf(fd, "%h %h %h", a, d, e);
          dataQ.push_back(d);
          errQ.push_back(e[0]);
          writeQ.push_back(cmd == "W");
        end
        else if (cmd == "E")
        begin
          code = $fscanf(fd, "%d", n);
          for (int i = 0; i < n; i++)
          begin
            code = $fscanf(fd, "%h", v);
            pixQ.push_back(v);
          end
        end
        else
          code = $fgets(lineText, fd);
      end
      $fclose(fd);
    end
  end

  // ========================================
  // APB transfers
  // ========================================
  always @(posedge D5M_PIXLCLK)
  begin
    regFails = 0;
    if (!rst && psel && penable && pready)
    begin
      if (dataQ.size() == 0)
      begin
        $display("APB transfer with no matching entry in the stimulus file");
        regFails++;
      end
      else
      begin
        expData  = dataQ.pop_front();
        expErr   = errQ.pop_front();
        expWrite = writeQ.pop_front();
        if (pslverr !== expErr)
        begin
          $display("FAILED pslverr: expected %h, got %h", expErr, pslverr);
          regFails++;
        end
        if (!expWrite && prdata !== expData)
        begin
          $display("FAILED prdata: expected %h, got %h", expData, prdata);
          regFails++;
        end
      end
    end
    if (endOfTest && !regDone)
    begin
      regDone = 1'b1;
      if (dataQ.size() != 0)
      begin
        $display("%0d APB transfers from the stimulus file never happened", dataQ.size());
        regFails += dataQ.size();
      end
    end
    regErrors <= regErrors + regFails;
  end

  // Output stream in order
  always @(posedge D5M_PIXLCLK)
  begin
    pixFails = 0;
    if (!rst && pixValid)
    begin
      pixSeen <= pixSeen + 1;
      if (pixQ.size() == 0)
      begin
        $display("Extra output pixel %h with nothing left to expect", pixOut);
        pixFails++;
      end
      else
      begin
        expPix = pixQ.pop_front();
        if (pixOut !== expPix)
        begin
          $display("FAILED pixOut: expected %h, got %h", expPix, pixOut);
          pixFails++;
        end
      end
    end
    if (endOfTest && !pixDone)
    begin
      pixDone = 1'b1;
      if (pixQ.size() != 0)
      begin
        $display("%0d expected output pixels never came out", pixQ.size());
        pixFails += pixQ.size();
      end
    end
    pixErrors <= pixErrors + pixFails;
  end

endmodule

//--- bench/camEdge_assert.sv
`timescale 1ns/1ps

module camEdgeAssert
(
  input logic D5M_PIXLCLK,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic pixValid
);

  // ========================================
  // APB slave
  // ========================================
  readyHigh: assert property (@(posedge D5M_PIXLCLK) pready)
    else $error("pready went low");

  // Error response only in an access phase
  errInAccess: assert property (@(posedge D5M_PIXLCLK) pslverr |-> (psel && penable))
    else $error("pslverr high outside an access phase");

  // Output stream quiet through reset and one cycle beyond
  quietAfterReset: assert property (@(posedge D5M_PIXLCLK) rst |=> !pixValid)
    else $error("pixValid high during or right after reset");

endmodule

bind camEdgeTop camEdgeAssert apbAndStream (.*);

//--- bench/camEdgeTb.sv
`timescale 1ns/1ps

module camEdgeTb
  import camEdgePkg::*;
();

  localparam int halfPeriod = 100;
  localparam int apbTimeout = 16;
  localparam int pixTimeout = 400;

  logic    D5M_PIXLCLK;
  logic    rst;
  pixelT   D5M_D;
  logic    D5M_FVAL;
  logic    D5M_LVAL;
  logic    psel;
  logic    penable;
  logic    pwrite;
  apbAddrT paddr;
  apbDataT pwdata;
  apbDataT prdata;
  logic    pready;
  logic    pslverr;
  pixelT   pixOut;
  logic    pixValid;
  logic    endOfTest;
  int      pixSeen;
  int      pixErrors;
  int      regErrors;
  int      runErrors;
  int      seed;
  int      expTotal;
  int      fd;
  int      code;
  byte     cmd;
  logic    fileDone;
  pixelT   rowPix [lineDepth];

  camEdgeTop i_dut (.*);

  pixelChecker pixCheck (
    .D5M_PIXLCLK (D5M_PIXLCLK), .rst (rst),
    .psel (psel), .penable (penable),
    .pready (pready), .pslverr (pslverr), .prdata (prdata),
    .pixOut (pixOut), .pixValid (pixValid), .endOfTest (endOfTest),
    .pixSeen (pixSeen), .pixErrors (pixErrors), .regErrors (regErrors)
  );

  initial D5M_PIXLCLK = 1'b0;
  always #halfPeriod D5M_PIXLCLK = ~D5M_PIXLCLK;

  // ========================================
  // Bus and sensor drivers
  // ========================================
  task automatic apbTransfer(input logic write, input apbAddrT addr, input apbDataT data);
    int waitCount;
    waitCount = 0;
    @(negedge D5M_PIXLCLK);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge D5M_PIXLCLK);
    penable = 1'b1;
    @(posedge D5M_PIXLCLK);
    while (!pready && waitCount < apbTimeout)
    begin
      @(posedge D5M_PIXLCLK);
      waitCount++;
    end
    if (!pready)
    begin
      $display("APB transfer to address %h never completed", addr);
      runErrors++;
    end
    @(negedge D5M_PIXLCLK);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic startFrame();
    @(negedge D5M_PIXLCLK);
    D5M_FVAL = 1'b1;
    repeat (2) @(negedge D5M_PIXLCLK);
  endtask

  // One row, then a random blanking gap of 2 to 9 cycles
  task automatic sendRow(input int n);
    int gap;
    gap = 2 + ($random(seed) & 7);
    for (int i = 0; i < n; i++)
    begin
      @(negedge D5M_PIXLCLK);
      D5M_LVAL = 1'b1;
      D5M_D    = rowPix[i];
    end
    @(negedge D5M_PIXLCLK);
    D5M_LVAL = 1'b0;
    D5M_D    = '0;
    repeat (gap - 1) @(negedge D5M_PIXLCLK);
  endtask

  task automatic waitForPixels(input int target);
    int waitCount;
    waitCount = 0;
    while (pixSeen < target && waitCount < pixTimeout)
    begin
      @(posedge D5M_PIXLCLK);
      waitCount++;
    end
    if (pixSeen < target)
    begin
      $display("Timeout: only %0d of %0d output pixels arrived", pixSeen, target);
      runErrors++;
    end
    else if (pixSeen > target)
    begin
      $display("Too many output pixels: %0d arrived where %0d were expected",
               pixSeen, target);
      runErrors++;
    end
  endtask

  task automatic endFrame();
    @(negedge D5M_PIXLCLK);
    D5M_FVAL = 1'b0;
    repeat (8) @(negedge D5M_PIXLCLK);
    waitForPixels(expTotal);
  endtask

  task automatic runCommand(input byte op);
    int          n;
    int          status;
    logic [31:0] fileAddr;
    logic [31:0] fileData;
    logic [31:0] fileErr;
    string       lineText;
    case (op)
      "W", "R":
      begin
        status = $fscanf(fd, "%h %h %h", fileAddr, fileData, fileErr);
        apbTransfer(op == "W", apbAddrT'(fileAddr), fileData);
      end
      "L":
      begin
        status = $fscanf(fd, "%d", n);
        for (int i = 0; i < n; i++)
          status = $fscanf(fd, "%h", rowPix[i]);
        sendRow(n);
      end
      // Only the pixel count is needed here
      "E":
      begin
        status = $fscanf(fd, "%d", n);
        expTotal += n;
        status = $fgets(lineText, fd);
      end
      "F": startFrame();
      "N": endFrame();
      "#": status = $fgets(lineText, fd);
      default:
      begin
        $display("Unknown command %c in the stimulus file", op);
        runErrors++;
        status = $fgets(lineText, fd);
      end
    endcase
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial
  begin
    seed      = 98518;
    runErrors = 0;
    expTotal  = 0;
    endOfTest = 1'b0;
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    D5M_D     = '0;
    D5M_FVAL  = 1'b0;
    D5M_LVAL  = 1'b0;
    repeat (2) @(posedge D5M_PIXLCLK);
    @(negedge D5M_PIXLCLK);
    rst = 1'b0;
    fd = $fopen("bench/camEdge_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file");
      runErrors++;
    end
    else
    begin
      fileDone = 1'b0;
      while (!fileDone)
      begin
        code = $fscanf(fd, " %c", cmd);
        if (code != 1)
          fileDone = 1'b1;
        else
          runCommand(cmd);
      end
      $fclose(fd);
    end
    @(negedge D5M_PIXLCLK);
    endOfTest = 1'b1;
    repeat (2) @(posedge D5M_PIXLCLK);
    $display("Errors: pixel %0d, register %0d, run %0d", pixErrors, regErrors, runErrors);
    if (pixErrors + regErrors + runErrors == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- camEdge.f
src/camEdgePkg.sv
src/lineBuffer.sv
src/ctrlRegs.sv
src/frameCapture.sv
src/bayerGray.sv
src/edgeDetect.sv
src/viewSelect.sv
src/camEdgeTop.sv
bench/pixelChecker.sv
bench/camEdge_assert.sv
bench/camEdgeTb.sv

//--- Bender.yml
package:
  name: camedge

sources:
  - src/camEdgePkg.sv
  - src/lineBuffer.sv
  - src/ctrlRegs.sv
  - src/frameCapture.sv
  - src/bayerGray.sv
  - src/edgeDetect.sv
  - src/viewSelect.sv
  - src/camEdgeTop.sv
  - target: test
    files:
      - bench/pixelChecker.sv
      - bench/camEdge_assert.sv
      - bench/camEdgeTb.sv

//--- bench/camEdge_stimulus.txt
# W/R addr data pslverr (hex), F frame start, N frame end
# L n pix... one raw row, E n pix... expected output of the frame (hex)
R 0 0 0
R 4 0 0
R 8 0 0
R C 0 0
W 4 7 0
R 4 7 0
W 2 5 1
R 2 0 1
R 4 7 0
W 4 0 0
F
L 4 111 222 333 444
L 4 555 666 777 888
E 0
N
W 0 1 0
R C 1 0
F
L 4 111 222 333 444
L 4 555 666 777 888
E 8 111 222 333 444 555 666 777 888
N
R 8 1 0
W 4 1 0
F
L 4 010 020 030 040
L 4 050 060 070 080
L 4 100 104 200 20C
L 4 108 110 300 314
E 4 038 058 107 288
N
W 4 2 0
F
L 4 010 020 030 040
L 4 050 060 070 080
L 4 100 104 200 20C
L 4 108 110 300 314
E 4 000 020 000 181
N
W 4 3 0
F
L 4 010 020 030 040
L 4 050 060 070 080
L 4 100 104 200 20C
L 4 108 110 300 314
E 4 000 000 0CF 230
N
W 4 4 0
F
L 4 010 020 030 040
L 4 050 060 070 080
L 4 100 104 200 20C
L 4 108 110 300 314
E 4 000 020 0CF 3B1
N
W 4 0 0
F
L 4 A01 A02 A03 A04
W 0 3 0
R C 2 0
L 4 B01 B02 B03 B04
E 8 A01 A02 A03 A04 B01 B02 B03 B04
N
F
L 4 C01 C02 C03 C04
E 0
N
R 8 6 0
R C 0 0
